/* Bender.yml */
package:
  name: mini_src_cpu

sources:
  - cpu_pkg.sv
  - mem_pkg.sv
  - alu.sv
  - register_file.sv
  - ram.sv
  - control_unit.sv
  - datapath.sv
  - cpu_top.sv
  - target: test
    files:
      - tb_cpu.sv

/* alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu (
	input  cpu_pkg::alu_op_t op,
	input  cpu_pkg::word_t   a,
	input  cpu_pkg::word_t   b,
	output cpu_pkg::word_t   result
);
	import cpu_pkg::*;

	always_comb begin
		case (op)
			alu_add: begin
				result = a + b;        // wraps mod 2^32
			end
			alu_sub: begin
				result = a - b;
			end
			alu_and: begin
				result = a & b;
			end
			alu_or: begin
				result = a | b;
			end
			alu_neg: begin
				result = ~b + 1'b1;    // two's complement
			end
			alu_not: begin
				result = ~b;
			end
			alu_pass_b: begin
				result = b;            // ldi, b is the effective address
			end
			default: begin
				result = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

/* control_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module control_unit (
	input  logic             clock,
	input  logic             reset,
	input  cpu_pkg::opcode_t opcode,
	input  logic             cond_true,
	output logic             ld_mar_pc,
	output logic             ld_mar_ea,
	output logic             ld_ir,
	output logic             ld_mdr,
	output logic             ld_pc_branch,
	output logic             ld_out,
	output logic             reg_write,
	output logic [1:0]       reg_src,
	output cpu_pkg::alu_op_t alu_op,
	output logic             mem_read,
	output logic             mem_write,
	output logic             halted
);
	import cpu_pkg::*;

	ctrl_state_t state;
	ctrl_state_t next_state;
	logic        writes_alu;   // result goes back through the alu path

	always_comb begin
		case (opcode)
			op_ldi, op_add, op_sub, op_and, op_or,
			op_addi, op_andi, op_ori, op_neg, op_not: writes_alu = 1'b1;
			default: writes_alu = 1'b0;
		endcase
	end

	// opcode to alu function
	always_comb begin
		case (opcode)
			op_sub:          alu_op = alu_sub;
			op_and, op_andi: alu_op = alu_and;
			op_or, op_ori:   alu_op = alu_or;
			op_neg:          alu_op = alu_neg;
			op_not:          alu_op = alu_not;
			op_ldi:          alu_op = alu_pass_b;
			default:         alu_op = alu_add;    // add, addi
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= fetch_addr;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			fetch_addr: next_state = fetch_wait;
			fetch_wait: next_state = fetch_ir;
			fetch_ir:   next_state = decode;
			decode:     next_state = (opcode == op_halt) ? halted_s : execute;
			execute: begin
				if (opcode == op_ld) begin
					next_state = mem_wait;
				end else if (writes_alu) begin
					next_state = writeback;
				end else begin
					next_state = fetch_addr;   // st, br, in, out, nop, unknown
				end
			end
			mem_wait:   next_state = writeback;
			writeback:  next_state = fetch_addr;
			halted_s:   next_state = halted_s;     // only reset leaves
			default:    next_state = fetch_addr;
		endcase
	end

	// outputs decoded from state, with the ir opcode as qualifier
	always_comb begin
		ld_mar_pc    = 1'b0;
		ld_mar_ea    = 1'b0;
		ld_ir        = 1'b0;
		ld_mdr       = 1'b0;
		ld_pc_branch = 1'b0;
		ld_out       = 1'b0;
		reg_write    = 1'b0;
		reg_src      = src_alu;
		mem_read     = 1'b0;
		mem_write    = 1'b0;
		case (state)
			fetch_addr: ld_mar_pc = 1'b1;   // mar <= pc, pc + 1
			fetch_wait: mem_read = 1'b1;
			fetch_ir:   ld_ir = 1'b1;
			decode:     ld_mar_ea = (opcode == op_ld) || (opcode == op_st);
			execute: begin
				mem_read     = (opcode == op_ld);
				mem_write    = (opcode == op_st);
				ld_pc_branch = (opcode == op_br) && cond_true;
				ld_out       = (opcode == op_out);
				reg_write    = (opcode == op_in);
				reg_src      = (opcode == op_in) ? src_in : src_alu;
			end
			mem_wait:   ld_mdr = 1'b1;      // read data valid now
			writeback: begin
				reg_write = 1'b1;
				reg_src   = (opcode == op_ld) ? src_mem : src_alu;
			end
			default: ;
		endcase
	end

	assign halted = (state == halted_s);

	// once halted the cpu stays put and touches no state
	a_halt_quiet: assert property (@(posedge clock) disable iff (reset)
		halted |=> halted && !mem_write && !reg_write)
		else $error("control_unit: activity after halt");

endmodule

`default_nettype wire

/* cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

	localparam int word_width = 32;
	localparam int imm_width  = 19;     // constant field c
	localparam int num_regs   = 16;

	typedef logic [word_width-1:0] word_t;
	typedef logic [3:0]            reg_idx_t;

	// five-bit major opcode in ir[31:27]
	typedef enum logic [4:0] {
		op_ld   = 5'd0,
		op_ldi  = 5'd1,
		op_st   = 5'd2,
		op_add  = 5'd3,
		op_sub  = 5'd4,
		op_and  = 5'd10,
		op_or   = 5'd11,
		op_addi = 5'd12,
		op_andi = 5'd13,
		op_ori  = 5'd14,
		op_neg  = 5'd17,
		op_not  = 5'd18,
		op_br   = 5'd19,    // condition in ir[20:19]
		op_in   = 5'd22,
		op_out  = 5'd23,
		op_nop  = 5'd26,
		op_halt = 5'd27
	} opcode_t;

	typedef enum logic [2:0] {
		alu_add, alu_sub, alu_and, alu_or, alu_neg, alu_not, alu_pass_b
	} alu_op_t;

	typedef enum logic [1:0] {
		cond_zero = 2'd0,
		cond_nonzero = 2'd1,
		cond_positive = 2'd2,
		cond_negative = 2'd3
	} cond_t;

	// register writeback source select
	localparam logic [1:0] src_alu = 2'd0;
	localparam logic [1:0] src_mem = 2'd1;
	localparam logic [1:0] src_in  = 2'd2;

	typedef enum logic [2:0] {
		fetch_addr, fetch_wait, fetch_ir, decode, execute, mem_wait, writeback, halted_s
	} ctrl_state_t;

endpackage

`default_nettype wire

/* cpu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_top (
	input  logic           clock,
	input  logic           reset,
	input  cpu_pkg::word_t in_port,
	output cpu_pkg::word_t out_port,
	output logic           halted
);
	import cpu_pkg::*;
	import mem_pkg::*;

	logic        ld_mar_pc, ld_mar_ea, ld_ir, ld_mdr, ld_pc_branch, ld_out;
	logic        reg_write, mem_read, mem_write, cond_true;
	logic [1:0]  reg_src;
	alu_op_t     alu_op;
	opcode_t     opcode;
	mem_addr_t   mem_addr;
	word_t       mem_rdata, mem_wdata;

	control_unit u_ctrl (
		.clock        (clock),
		.reset        (reset),
		.opcode       (opcode),
		.cond_true    (cond_true),
		.ld_mar_pc    (ld_mar_pc),
		.ld_mar_ea    (ld_mar_ea),
		.ld_ir        (ld_ir),
		.ld_mdr       (ld_mdr),
		.ld_pc_branch (ld_pc_branch),
		.ld_out       (ld_out),
		.reg_write    (reg_write),
		.reg_src      (reg_src),
		.alu_op       (alu_op),
		.mem_read     (mem_read),
		.mem_write    (mem_write),
		.halted       (halted)
	);

	datapath u_dp (
		.clock        (clock),
		.reset        (reset),
		.ld_mar_pc    (ld_mar_pc),
		.ld_mar_ea    (ld_mar_ea),
		.ld_ir        (ld_ir),
		.ld_mdr       (ld_mdr),
		.ld_pc_branch (ld_pc_branch),
		.ld_out       (ld_out),
		.reg_write    (reg_write),
		.reg_src      (reg_src),
		.alu_op       (alu_op),
		.mem_rdata    (mem_rdata),
		.in_port      (in_port),
		.opcode       (opcode),
		.cond_true    (cond_true),
		.mem_addr     (mem_addr),
		.mem_wdata    (mem_wdata),
		.out_port     (out_port)
	);

	ram u_mem (
		.clock    (clock),
		.address  (mem_addr),
		.data_in  (mem_wdata),
		.read     (mem_read),
		.write    (mem_write),
		.data_out (mem_rdata)
	);

endmodule

`default_nettype wire

/* datapath.sv */
`timescale 1ns/1ps
`default_nettype none

module datapath (
	input  logic               clock,
	input  logic               reset,
	input  logic               ld_mar_pc,
	input  logic               ld_mar_ea,
	input  logic               ld_ir,
	input  logic               ld_mdr,
	input  logic               ld_pc_branch,
	input  logic               ld_out,
	input  logic               reg_write,
	input  logic [1:0]         reg_src,
	input  cpu_pkg::alu_op_t   alu_op,
	input  cpu_pkg::word_t     mem_rdata,
	input  cpu_pkg::word_t     in_port,
	output cpu_pkg::opcode_t   opcode,
	output logic               cond_true,
	output mem_pkg::mem_addr_t mem_addr,
	output cpu_pkg::word_t     mem_wdata,
	output cpu_pkg::word_t     out_port
);
	import cpu_pkg::*;
	import mem_pkg::*;

	word_t     pc, ir, mdr;
	mem_addr_t mar;
	reg_idx_t  ra, rb, rc, read_a_idx;
	word_t     imm, read_a, read_b, base, ea;
	word_t     alu_b, alu_result, wb_data;
	cond_t     cond;
	logic      reg_form;   // three-register add, sub, and, or

	// instruction fields
	assign opcode = opcode_t'(ir[31:27]);
	assign ra     = ir[26:23];
	assign rb     = ir[22:19];
	assign rc     = ir[18:15];
	assign cond   = cond_t'(ir[20:19]);
	assign imm    = {{(word_width-imm_width){ir[imm_width-1]}}, ir[imm_width-1:0]};

	assign reg_form   = opcode inside {op_add, op_sub, op_and, op_or};
	assign read_a_idx = reg_form ? rc : ra;    // port a: rc, or ra for st/br/out

	register_file u_rf (
		.clock      (clock),
		.write      (reg_write),
		.write_idx  (ra),
		.write_data (wb_data),
		.read_a_idx (read_a_idx),
		.read_b_idx (rb),
		.read_a     (read_a),
		.read_b     (read_b)
	);

	assign base = (rb == '0) ? '0 : read_b;  // r0 as base means no base
	assign ea   = base + imm;

	always_comb begin
		case (opcode)
			op_add, op_sub, op_and, op_or: alu_b = read_a;
			op_neg, op_not:                alu_b = read_b;   // unary on rb
			op_ldi:                        alu_b = ea;
			default:                       alu_b = imm;      // addi, andi, ori
		endcase
	end

	alu u_alu (
		.op     (alu_op),
		.a      (read_b),
		.b      (alu_b),
		.result (alu_result)
	);

	// branch test on ra
	always_comb begin
		case (cond)
			cond_zero:     cond_true = (read_a == '0);
			cond_nonzero:  cond_true = (read_a != '0);
			cond_positive: cond_true = !read_a[31] && (read_a != '0);
			default:       cond_true = read_a[31];
		endcase
	end

	always_comb begin
		case (reg_src)
			src_mem: wb_data = mdr;
			src_in:  wb_data = in_port;
			default: wb_data = alu_result;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			pc       <= '0;
			ir       <= '0;
			mar      <= '0;
			mdr      <= '0;
			out_port <= '0;
		end else begin
			if (ld_mar_pc) begin
				mar <= pc[addr_width-1:0];
				pc  <= pc + 1'b1;
			end
			if (ld_mar_ea)    mar <= ea[addr_width-1:0];   // wraps mod 512
			if (ld_pc_branch) pc <= pc + imm;              // pc already points past br
			if (ld_ir)        ir <= mem_rdata;
			if (ld_mdr)       mdr <= mem_rdata;
			if (ld_out)       out_port <= read_a;
		end
	end

	assign mem_addr  = mar;
	assign mem_wdata = read_a;   // st data is ra

	a_mar_src: assert property (@(posedge clock) disable iff (reset)
		!(ld_mar_pc && ld_mar_ea))
		else $error("datapath: two mar sources in one cycle");

endmodule

`default_nettype wire

/* mem_pkg.sv */
`default_nettype none

package mem_pkg;

	// one array for program and data
	localparam int mem_depth  = 512;
	localparam int addr_width = 9;     // log2 of mem_depth

	// word address, upper bits of an effective address fall away
	typedef logic [addr_width-1:0] mem_addr_t;

endpackage

`default_nettype wire

/* ram.sv */
`timescale 1ns/1ps
`default_nettype none

module ram (
	input  logic               clock,
	input  mem_pkg::mem_addr_t address,
	input  cpu_pkg::word_t     data_in,
	input  logic               read,
	input  logic               write,
	output cpu_pkg::word_t     data_out
);
	import cpu_pkg::*;
	import mem_pkg::*;

	word_t ram [mem_depth];   // program and data share this

	// write lands at the strobe edge
	always_ff @(posedge clock) begin
		if (write) begin
			ram[address] <= data_in;
		end
	end

	// read data shows up the cycle after the strobe, then holds
	always_ff @(posedge clock) begin
		if (read) begin
			data_out <= ram[address];
		end
	end

	// control unit never drives both strobes in the same cycle
	a_strobe_excl: assert property (@(posedge clock) !(read && write))
		else $error("ram: read and write asserted together");

endmodule

`default_nettype wire

/* register_file.sv */
`timescale 1ns/1ps
`default_nettype none

module register_file (
	input  logic              clock,
	input  logic              write,
	input  cpu_pkg::reg_idx_t write_idx,
	input  cpu_pkg::word_t    write_data,
	input  cpu_pkg::reg_idx_t read_a_idx,
	input  cpu_pkg::reg_idx_t read_b_idx,
	output cpu_pkg::word_t    read_a,
	output cpu_pkg::word_t    read_b
);
	import cpu_pkg::*;

	word_t regs [num_regs];   // r0..r15, r0 is a normal register here

	always_ff @(posedge clock) begin
		if (write) begin
			regs[write_idx] <= write_data;
		end
	end

	// reads see the value from before a same-cycle write
	assign read_a = regs[read_a_idx];
	assign read_b = regs[read_b_idx];

endmodule

`default_nettype wire

/* tb.f */
cpu_pkg.sv
mem_pkg.sv
alu.sv
register_file.sv
ram.sv
control_unit.sv
datapath.sv
cpu_top.sv
tb_cpu.sv

/* tb_cpu.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cpu;
	import cpu_pkg::*;
	import mem_pkg::*;

	localparam int reset_cycles = 5;
	localparam int run_limit    = 200;   // cycles allowed from reset release to halt
	localparam int num_tests    = 6;
	// six full run budgets, the resets, then room for the post-halt waits
	localparam int cycle_limit  = num_tests * (run_limit + 2 * reset_cycles) + 240;

	logic  clock;
	logic  reset;
	word_t in_port;
	word_t out_port;
	logic  halted;

	integer seed = 32'h1ad0;
	int     errors = 0;
	int     checks = 0;
	int     cycle_count = 0;
	word_t  prog [$];   // program image with word 0 first

	cpu_top u_dut (
		.clock    (clock),
		.reset    (reset),
		.in_port  (in_port),
		.out_port (out_port),
		.halted   (halted)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	initial begin
		reset   = 1'b1;
		in_port = '0;
	end

	// backstop in case a run gets stuck somewhere
	initial begin
		while (cycle_count < cycle_limit) begin
			@(posedge clock);
			cycle_count++;
		end
		$display("run stopped after %0d cycles without finishing the tests", cycle_limit);
		$display("%0d checks, %0d errors", checks, errors);
		$display("*** TEST FAILED ***");
		$finish;
	end

	// op sits in 31..27, ra in 26..23, rb in 22..19, rc in 18..15 and c in 18..0
	function automatic word_t enc_reg(opcode_t op, reg_idx_t ra, reg_idx_t rb, reg_idx_t rc);
		return {op, ra, rb, rc, 15'd0};
	endfunction

	function automatic word_t enc_imm(opcode_t op, reg_idx_t ra, reg_idx_t rb,
			logic [imm_width-1:0] c);
		return {op, ra, rb, c};
	endfunction

	function automatic word_t enc_branch(reg_idx_t ra, cond_t cond, logic [imm_width-1:0] c);
		return {op_br, ra, 2'b00, cond, c};   // condition sits in the low bits of rb
	endfunction

	function automatic word_t sext(logic [imm_width-1:0] c);
		return {{(32 - imm_width){c[imm_width-1]}}, c};
	endfunction

	// reference model of the ops where a is the rb operand
	function automatic word_t expect_result(opcode_t op, word_t a, word_t b);
		case (op)
			op_add, op_addi: return a + b;
			op_sub:          return a - b;
			op_and, op_andi: return a & b;
			op_or, op_ori:   return a | b;
			op_neg:          return -a;
			op_not:          return ~a;
			default:         return '0;
		endcase
	endfunction

	function automatic logic cond_holds(cond_t cond, word_t v);
		case (cond)
			cond_zero:     return v == 0;
			cond_nonzero:  return v != 0;
			cond_positive: return !v[31] && v != 0;
			default:       return v[31];
		endcase
	endfunction

	task automatic check_word(input string name, input word_t expected, input word_t actual);
		checks++;
		if (actual !== expected) begin
			$display("FAIL %s: expected %h, got %h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		checks++;
		if (actual !== expected) begin
			$display("FAIL %s: expected %b, got %b", name, expected, actual);
			errors++;
		end
	endtask

	task automatic emit(input word_t w);
		prog.push_back(w);
	endtask

	task automatic load_word(input mem_addr_t addr, input word_t data);
		if (reset !== 1'b1) begin
			$display("ERROR: memory preload attempted while reset was low");
			errors++;
		end else begin
			u_dut.u_mem.ram[addr] = data;
		end
	endtask

	// unused words decode as halt and carry their address in the low bits
	task automatic fill_memory();
		mem_addr_t addr;
		for (int a = 0; a < mem_depth; a++) begin
			addr = mem_addr_t'(a);
			load_word(addr, {op_halt, {(32 - 5 - addr_width){1'b0}}, addr});
		end
	endtask

	task automatic run_until_halt(input string name);
		int waited;
		waited = 0;
		while (halted !== 1'b1 && waited < run_limit) begin
			@(negedge clock);
			waited++;
		end
		if (halted !== 1'b1) begin
			$display("ERROR: %s never halted within %0d cycles", name, run_limit);
			errors++;
		end
	endtask

	// preload prog under reset, then release and run to halt
	task automatic exec_program(input string name, input word_t in_value);
		@(posedge clock);
		reset   <= 1'b1;
		in_port <= in_value;
		@(posedge clock);
		fill_memory();
		foreach (prog[i]) load_word(mem_addr_t'(i), prog[i]);
		repeat (reset_cycles - 1) @(posedge clock);
		reset <= 1'b0;
		run_until_halt(name);
	endtask

	// r1 = ca, r2 = cb, then op_word into r3 and out r3
	task automatic run_op_case(input string name, input logic [imm_width-1:0] ca,
			input logic [imm_width-1:0] cb, input word_t op_word, input word_t expected);
		prog.delete();
		emit(enc_imm(op_ldi, 4'd1, 4'd0, ca));
		emit(enc_imm(op_ldi, 4'd2, 4'd0, cb));
		emit(op_word);
		emit(enc_reg(op_out, 4'd3, 4'd0, 4'd0));
		emit(enc_reg(op_halt, 4'd0, 4'd0, 4'd0));
		exec_program(name, '0);
		check_word(name, expected, out_port);
	endtask

	task automatic test_arith();
		logic [imm_width-1:0] ca, cb;
		opcode_t ops [4];
		ca = $random(seed);
		cb = $random(seed);
		ops[0] = op_add;
		ops[1] = op_sub;
		ops[2] = op_and;
		ops[3] = op_or;
		foreach (ops[i]) begin
			run_op_case($sformatf("test_arith %s", ops[i].name()), ca, cb,
				enc_reg(ops[i], 4'd3, 4'd1, 4'd2), expect_result(ops[i], sext(ca), sext(cb)));
		end
	endtask

	task automatic test_immediate();
		logic [imm_width-1:0] x, cneg, cm;
		word_t xs;
		x    = $random(seed);
		cneg = {1'b1, 18'($random(seed))};   // sign bit set so it extends to ones
		cm   = $random(seed);
		xs   = sext(x);
		run_op_case("test_immediate addi", x, '0, enc_imm(op_addi, 4'd3, 4'd1, cneg),
			expect_result(op_addi, xs, sext(cneg)));
		run_op_case("test_immediate andi", x, '0, enc_imm(op_andi, 4'd3, 4'd1, cm),
			expect_result(op_andi, xs, sext(cm)));
		run_op_case("test_immediate ori", x, '0, enc_imm(op_ori, 4'd3, 4'd1, cm),
			expect_result(op_ori, xs, sext(cm)));
		run_op_case("test_immediate neg", x, '0, enc_reg(op_neg, 4'd3, 4'd1, 4'd0),
			expect_result(op_neg, xs, '0));
		run_op_case("test_immediate not", x, '0, enc_reg(op_not, 4'd3, 4'd1, 4'd0),
			expect_result(op_not, xs, '0));
	endtask

	task automatic test_load_store();
		word_t                data;
		mem_addr_t            addr;
		int                   k;
		logic [imm_width-1:0] off;
		data = $random(seed);
		addr = {1'b1, 8'($random(seed))};    // upper half stays clear of the program
		k    = 1 + ($random(seed) & 63);
		off  = -k;
		prog.delete();
		emit(enc_reg(op_in, 4'd1, 4'd0, 4'd0));
		emit(enc_imm(op_ldi, 4'd0, 4'd0, 19'h00abc));          // junk in r0 that the base must ignore
		emit(enc_imm(op_st, 4'd1, 4'd0, 19'(addr)));           // store via r0 base
		emit(enc_imm(op_ldi, 4'd3, 4'd0, 19'(addr) + 19'(k)));
		emit(enc_imm(op_ld, 4'd5, 4'd3, off));                 // same word through another base
		emit(enc_reg(op_out, 4'd5, 4'd0, 4'd0));
		emit(enc_reg(op_halt, 4'd0, 4'd0, 4'd0));
		exec_program("test_load_store", data);
		check_word("test_load_store out", data, out_port);
		check_word("test_load_store memory", data, u_dut.u_mem.ram[addr]);
	endtask

	task automatic test_branch();
		logic [imm_width-1:0] vals [3];
		logic [imm_width-1:0] taken_mark, fall_mark;
		cond_t                cond;
		string                name;
		taken_mark = 19'h00a5a;
		fall_mark  = 19'h005a5;
		vals[0] = '0;
		vals[1] = {1'b0, 17'($random(seed)), 1'b1};   // positive and never zero
		vals[2] = {1'b1, 18'($random(seed))};         // negative
		for (int ci = 0; ci < 4; ci++) begin
			cond = cond_t'(ci);
			foreach (vals[i]) begin
				name = $sformatf("test_branch %s value %h", cond.name(), sext(vals[i]));
				prog.delete();
				emit(enc_imm(op_ldi, 4'd1, 4'd0, vals[i]));
				emit(enc_branch(4'd1, cond, 19'd3));          // target 2 + 3
				emit(enc_imm(op_ldi, 4'd2, 4'd0, fall_mark));
				emit(enc_reg(op_out, 4'd2, 4'd0, 4'd0));
				emit(enc_reg(op_halt, 4'd0, 4'd0, 4'd0));
				emit(enc_imm(op_ldi, 4'd2, 4'd0, taken_mark));
				emit(enc_reg(op_out, 4'd2, 4'd0, 4'd0));
				emit(enc_reg(op_halt, 4'd0, 4'd0, 4'd0));
				exec_program(name, '0);
				check_word(name, cond_holds(cond, sext(vals[i])) ? sext(taken_mark)
					: sext(fall_mark), out_port);
			end
		end
	endtask

	task automatic test_io();
		word_t data;
		data = $random(seed);
		prog.delete();
		emit(enc_reg(op_in, 4'd7, 4'd0, 4'd0));
		emit(enc_reg(op_out, 4'd7, 4'd0, 4'd0));
		emit(enc_reg(op_halt, 4'd0, 4'd0, 4'd0));
		exec_program("test_io", data);
		check_word("test_io", data, out_port);
	endtask

	task automatic test_reset_halt();
		logic [imm_width-1:0] c;
		c = $random(seed);
		prog.delete();
		emit(enc_imm(op_ldi, 4'd4, 4'd0, c));
		emit(enc_reg(op_out, 4'd4, 4'd0, 4'd0));
		emit(enc_reg(op_halt, 4'd0, 4'd0, 4'd0));
		exec_program("test_reset_halt", '0);
		check_bit("test_reset_halt halted", 1'b1, halted);
		check_word("test_reset_halt out", sext(c), out_port);
		repeat (2 * reset_cycles) @(negedge clock);
		check_bit("test_reset_halt halted held", 1'b1, halted);
		check_word("test_reset_halt out held", sext(c), out_port);
		@(posedge clock);
		reset <= 1'b1;
		@(posedge clock);   // first edge that sees reset high
		@(negedge clock);
		check_bit("test_reset_halt halted cleared", 1'b0, halted);
		check_word("test_reset_halt out cleared", '0, out_port);
		repeat (reset_cycles - 1) @(posedge clock);
		reset <= 1'b0;
		// memory is not reset, so the same program runs again
		run_until_halt("test_reset_halt rerun");
		check_word("test_reset_halt rerun out", sext(c), out_port);
	endtask

	initial begin
		test_arith();
		test_immediate();
		test_load_store();
		test_branch();
		test_io();
		test_reset_halt();
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire
